/* verilog.f */
source/thread_pkg.sv
source/thread_table.sv
source/thread_cmd_unit.sv
source/thread_scheduler.sv
source/threads_manager.sv
tb/threads_manager_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the threads_manager testbench with verilator

cd "$(dirname "$0")" || exit 1

TOP=threads_manager_tb
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module "$TOP" -Mdir obj_dir -f verilog.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/V"$TOP" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "=== PASS ===" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1

/* tb/threads_manager_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module threads_manager_tb;

  import thread_pkg::*;

  localparam int PROC_QUANTITY = 4;
  localparam int CNT_W         = $clog2(PROC_QUANTITY + 1);
  localparam int ENT_W         = CTX_W + ADDR_W;
  localparam int N_TESTS       = 7;
  localparam int WAIT_LIMIT    = 8;
  // tests x 200 cycles x 40 ns
  localparam int TIMEOUT_NS    = N_TESTS * 200 * 40;

  logic              clk;
  logic              rst;
  logic              cmd_valid_i;
  thread_cmd_t       cmd_i;
  logic [CTX_W-1:0]  ctx_i;
  logic [ADDR_W-1:0] addr_i;
  thread_rslt_t      rslt_o;
  logic              rslt_valid_o;
  logic              next_thread_i;
  logic [CTX_W-1:0]  next_ctx_o;
  logic [ADDR_W-1:0] next_addr_o;
  logic              next_valid_o;
  logic              sched_done_o;
  logic [CNT_W-1:0]  thread_count_o;

  // reference model, entries packed as {ctx, addr}
  logic [ENT_W-1:0] tbl_q[$];
  int               rr_idx;
  logic             fork_pend;
  logic [ENT_W-1:0] fork_ent;
  logic             stop_pend;
  logic [ENT_W-1:0] stop_ent;
  int               miss_budget;
  int               checks;
  int               errors;
  int unsigned      seed;

  threads_manager #(
    .PROC_QUANTITY (PROC_QUANTITY)
  ) dut (.*);

  initial clk = 1'b0;
  always #20 clk = ~clk;

  task automatic check_rslt(input thread_rslt_t want);
    checks++;
    if (rslt_o !== want) begin
      errors++;
      $display("** Error: rslt_o expected %h got %h", want, rslt_o);
    end
  endtask

  // ctx and addr only matter while valid is high
  task automatic check_thread(input logic [ENT_W-1:0] want, input logic want_valid);
    checks++;
    if (next_valid_o !== want_valid) begin
      errors++;
      $display("** Error: next_valid_o expected %h got %h", want_valid, next_valid_o);
    end else if (want_valid && ({next_ctx_o, next_addr_o} !== want)) begin
      errors++;
      $display("** Error: next_ctx_o/next_addr_o expected %h/%h got %h/%h",
               want[ENT_W-1:ADDR_W], want[ADDR_W-1:0], next_ctx_o, next_addr_o);
    end
  endtask

  task automatic check_count(input logic [CNT_W-1:0] want);
    checks++;
    if (thread_count_o !== want) begin
      errors++;
      $display("** Error: thread_count_o expected %h got %h", want, thread_count_o);
    end
  endtask

  function automatic logic [ENT_W-1:0] rand_entry();
    return {CTX_W'($urandom), ADDR_W'($urandom)};
  endfunction

  function automatic logic [ENT_W-1:0] absent_entry();
    logic [ENT_W-1:0] ent;
    logic             hit;
    // redraw until no table entry matches
    do begin
      ent = rand_entry();
      hit = 1'b0;
      foreach (tbl_q[i]) begin
        if (tbl_q[i] == ent) begin
          hit = 1'b1;
        end
      end
    end while (hit);
    return ent;
  endfunction

  // one command strobe, result expected exactly one cycle later
  task automatic send_cmd(input thread_cmd_t cmd, input logic [ENT_W-1:0] ent);
    thread_rslt_t want;
    want = RSLT_BUSY;
    @(posedge clk);
    #2;
    cmd_valid_i      = 1'b1;
    cmd_i            = cmd;
    {ctx_i, addr_i}  = ent;
    // one fork slot and room in the table
    if ((cmd == CMD_RUN) && !fork_pend && (tbl_q.size() < PROC_QUANTITY)) begin
      want      = RSLT_OK;
      fork_pend = 1'b1;
      fork_ent  = ent;
    end else if ((cmd == CMD_STOP) && !stop_pend) begin
      want        = RSLT_OK;
      stop_pend   = (tbl_q.size() != 0);
      stop_ent    = ent;
      miss_budget = tbl_q.size();
    end
    @(posedge clk);
    #2;
    cmd_valid_i = 1'b0;
    cmd_i       = CMD_NONE;
    @(negedge clk);
    if (!rslt_valid_o) begin
      errors++;
      $display("rslt_valid_o did not pulse one cycle after the command");
    end else begin
      check_rslt(want);
    end
  endtask

  // one next-thread strobe, model step, wait for done and compare
  task automatic strobe_next();
    logic [ENT_W-1:0] want;
    logic             want_valid;
    int               want_lat;
    int               lat;
    int               last;
    int               sel;
    want       = '0;
    want_valid = 1'b0;
    want_lat   = 1;
    @(posedge clk);
    #2;
    next_thread_i = 1'b1;
    if (fork_pend) begin
      // parked fork goes in at the end and is selected
      tbl_q.push_back(fork_ent);
      want       = fork_ent;
      want_valid = 1'b1;
      fork_pend  = 1'b0;
    end else if (tbl_q.size() == 0) begin
      want_valid = 1'b0;
    end else if (stop_pend && (tbl_q[rr_idx] == stop_ent)) begin
      // swap with last, then reselect at the same index
      want_lat = 2;
      last     = tbl_q.size() - 1;
      sel      = 0;
      if (rr_idx < last) begin
        tbl_q[rr_idx] = tbl_q[last];
        sel           = rr_idx;
      end
      tbl_q.delete(last);
      stop_pend = 1'b0;
      if (tbl_q.size() == 0) begin
        rr_idx = 0;
      end else begin
        want       = tbl_q[sel];
        want_valid = 1'b1;
        rr_idx     = (sel + 1 >= tbl_q.size()) ? 0 : sel + 1;
      end
    end else begin
      want       = tbl_q[rr_idx];
      want_valid = 1'b1;
      rr_idx     = (rr_idx + 1 >= tbl_q.size()) ? 0 : rr_idx + 1;
      // each miss spends one unit of the stop budget
      if (stop_pend) begin
        miss_budget--;
        if (miss_budget == 0) begin
          stop_pend = 1'b0;
        end
      end
    end
    @(posedge clk);
    #2;
    next_thread_i = 1'b0;
    lat = 0;
    do begin
      @(negedge clk);
      lat++;
    end while (!sched_done_o && (lat < WAIT_LIMIT));
    if (!sched_done_o) begin
      errors++;
      $display("sched_done_o did not arrive within %0d cycles", WAIT_LIMIT);
    end else begin
      if (lat != want_lat) begin
        errors++;
        $display("selection took %0d cycles instead of %0d", lat, want_lat);
      end
      check_thread(want, want_valid);
      check_count(CNT_W'(tbl_q.size()));
    end
  endtask

  task automatic empty_after_reset();
    @(negedge clk);
    check_count('0);
    strobe_next();
  endtask

  task automatic fork_and_rotate();
    int i;
    for (i = 0; i < PROC_QUANTITY; i++) begin
      send_cmd(CMD_RUN, rand_entry());
      strobe_next();
    end
    // full table, append order and wrap
    for (i = 0; i < PROC_QUANTITY + 2; i++) begin
      strobe_next();
    end
  endtask

  task automatic run_when_full();
    send_cmd(CMD_RUN, rand_entry());
    strobe_next();
  endtask

  task automatic stop_present_thread();
    logic [ENT_W-1:0] target;
    int               i;
    // not the last entry, so the swap really moves one
    target = tbl_q[1];
    send_cmd(CMD_STOP, target);
    send_cmd(CMD_STOP, absent_entry());
    for (i = 0; i < PROC_QUANTITY + 2; i++) begin
      strobe_next();
      if (next_valid_o && ({next_ctx_o, next_addr_o} == target)) begin
        errors++;
        $display("stopped thread %h was scheduled again", target);
      end
    end
  endtask

  task automatic stop_absent_thread();
    int i;
    int n;
    // second round shows the slot is free again
    for (i = 0; i < 2; i++) begin
      n = tbl_q.size();
      send_cmd(CMD_STOP, absent_entry());
      repeat (n - 1) strobe_next();
      // budget has one selection left here
      send_cmd(CMD_STOP, absent_entry());
      strobe_next();
    end
  endtask

  task automatic stop_last_thread();
    // stop whatever the index points at, until empty
    while (tbl_q.size() > 0) begin
      send_cmd(CMD_STOP, tbl_q[rr_idx]);
      strobe_next();
    end
    strobe_next();
  endtask

  task automatic run_while_fork_parked();
    send_cmd(CMD_RUN, rand_entry());
    send_cmd(CMD_RUN, rand_entry());
    strobe_next();
  endtask

  // watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("run timed out after %0d ns", TIMEOUT_NS);
    $display("=== FAIL ===");
    $finish;
  end

  initial begin
    checks        = 0;
    errors        = 0;
    rr_idx        = 0;
    fork_pend     = 1'b0;
    fork_ent      = '0;
    stop_pend     = 1'b0;
    stop_ent      = '0;
    miss_budget   = 0;
    rst           = 1'b1;
    cmd_valid_i   = 1'b0;
    cmd_i         = CMD_NONE;
    ctx_i         = '0;
    addr_i        = '0;
    next_thread_i = 1'b0;
    seed          = $urandom(32'h95a8d467);
    repeat (5) @(posedge clk);
    #2;
    rst = 1'b0;
    empty_after_reset();
    fork_and_rotate();
    run_when_full();
    stop_present_thread();
    stop_absent_thread();
    stop_last_thread();
    run_while_fork_parked();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* source/threads_manager.sv */
`timescale 1ns/1ps
`default_nettype none

module threads_manager #(
  parameter int  PROC_QUANTITY = 8,
  localparam int CNT_W         = $clog2(PROC_QUANTITY + 1)
) (
  input  wire                           clk,
  input  wire                           rst,
  input  wire                           cmd_valid_i,
  input  wire thread_pkg::thread_cmd_t  cmd_i,
  input  wire [thread_pkg::CTX_W-1:0]   ctx_i,
  input  wire [thread_pkg::ADDR_W-1:0]  addr_i,
  output thread_pkg::thread_rslt_t      rslt_o,
  output logic                          rslt_valid_o,
  input  wire                           next_thread_i,
  output logic [thread_pkg::CTX_W-1:0]  next_ctx_o,
  output logic [thread_pkg::ADDR_W-1:0] next_addr_o,
  output logic                          next_valid_o,
  output logic                          sched_done_o,
  output logic [CNT_W-1:0]              thread_count_o
);

  import thread_pkg::*;

  localparam int IDX_W = (PROC_QUANTITY > 1) ? $clog2(PROC_QUANTITY) : 1;

  // command unit to scheduler
  logic              fork_pend;
  logic [CTX_W-1:0]  fork_ctx;
  logic [ADDR_W-1:0] fork_addr;
  logic              stop_pend;
  logic [CTX_W-1:0]  stop_ctx;
  logic [ADDR_W-1:0] stop_addr;
  logic              fork_take;
  logic              stop_hit;
  logic              sel_miss;

  // scheduler to table
  logic              wr_en;
  logic [IDX_W-1:0]  wr_idx;
  logic [CTX_W-1:0]  wr_ctx;
  logic [ADDR_W-1:0] wr_addr;
  logic              append;
  logic              remove;
  logic [IDX_W-1:0]  rd_idx;
  logic [CTX_W-1:0]  rd_ctx;
  logic [ADDR_W-1:0] rd_addr;
  // shared by all three blocks
  logic [CNT_W-1:0]  count;

  // run and stop handling
  thread_cmd_unit #(
    .PROC_QUANTITY (PROC_QUANTITY)
  ) u_cmd (
    .clk          (clk),
    .rst          (rst),
    .cmd_valid_i  (cmd_valid_i),
    .cmd_i        (cmd_i),
    .ctx_i        (ctx_i),
    .addr_i       (addr_i),
    .count_i      (count),
    .fork_take_i  (fork_take),
    .stop_hit_i   (stop_hit),
    .sel_miss_i   (sel_miss),
    .fork_pend_o  (fork_pend),
    .fork_ctx_o   (fork_ctx),
    .fork_addr_o  (fork_addr),
    .stop_pend_o  (stop_pend),
    .stop_ctx_o   (stop_ctx),
    .stop_addr_o  (stop_addr),
    .rslt_o       (rslt_o),
    .rslt_valid_o (rslt_valid_o)
  );

  // round robin selection
  thread_scheduler #(
    .PROC_QUANTITY (PROC_QUANTITY)
  ) u_sched (
    .clk           (clk),
    .rst           (rst),
    .next_thread_i (next_thread_i),
    .fork_pend_i   (fork_pend),
    .fork_ctx_i    (fork_ctx),
    .fork_addr_i   (fork_addr),
    .stop_pend_i   (stop_pend),
    .stop_ctx_i    (stop_ctx),
    .stop_addr_i   (stop_addr),
    .count_i       (count),
    .rd_ctx_i      (rd_ctx),
    .rd_addr_i     (rd_addr),
    .fork_take_o   (fork_take),
    .stop_hit_o    (stop_hit),
    .sel_miss_o    (sel_miss),
    .append_o      (append),
    .remove_o      (remove),
    .wr_en_o       (wr_en),
    .wr_idx_o      (wr_idx),
    .wr_ctx_o      (wr_ctx),
    .wr_addr_o     (wr_addr),
    .rd_idx_o      (rd_idx),
    .next_ctx_o    (next_ctx_o),
    .next_addr_o   (next_addr_o),
    .next_valid_o  (next_valid_o),
    .sched_done_o  (sched_done_o)
  );

  // active thread storage
  thread_table #(
    .PROC_QUANTITY (PROC_QUANTITY)
  ) u_table (
    .clk       (clk),
    .rst       (rst),
    .append_i  (append),
    .remove_i  (remove),
    .wr_en_i   (wr_en),
    .wr_idx_i  (wr_idx),
    .wr_ctx_i  (wr_ctx),
    .wr_addr_i (wr_addr),
    .rd_idx_i  (rd_idx),
    .rd_ctx_o  (rd_ctx),
    .rd_addr_o (rd_addr),
    .count_o   (count)
  );

  assign thread_count_o = count;

endmodule

`default_nettype wire

/* source/thread_scheduler.sv */
`timescale 1ns/1ps
`default_nettype none

module thread_scheduler #(
  parameter int  PROC_QUANTITY = 8,
  localparam int CNT_W         = $clog2(PROC_QUANTITY + 1),
  localparam int IDX_W         = (PROC_QUANTITY > 1) ? $clog2(PROC_QUANTITY) : 1
) (
  input  wire                           clk,
  input  wire                           rst,
  input  wire                           next_thread_i,
  input  wire                           fork_pend_i,
  input  wire [thread_pkg::CTX_W-1:0]   fork_ctx_i,
  input  wire [thread_pkg::ADDR_W-1:0]  fork_addr_i,
  input  wire                           stop_pend_i,
  input  wire [thread_pkg::CTX_W-1:0]   stop_ctx_i,
  input  wire [thread_pkg::ADDR_W-1:0]  stop_addr_i,
  input  wire [CNT_W-1:0]               count_i,
  input  wire [thread_pkg::CTX_W-1:0]   rd_ctx_i,
  input  wire [thread_pkg::ADDR_W-1:0]  rd_addr_i,
  output logic                          fork_take_o,
  output logic                          stop_hit_o,
  output logic                          sel_miss_o,
  output logic                          append_o,
  output logic                          remove_o,
  output logic                          wr_en_o,
  output logic [IDX_W-1:0]              wr_idx_o,
  output logic [thread_pkg::CTX_W-1:0]  wr_ctx_o,
  output logic [thread_pkg::ADDR_W-1:0] wr_addr_o,
  output logic [IDX_W-1:0]              rd_idx_o,
  output logic [thread_pkg::CTX_W-1:0]  next_ctx_o,
  output logic [thread_pkg::ADDR_W-1:0] next_addr_o,
  output logic                          next_valid_o,
  output logic                          sched_done_o
);

  // IDLE waits for a strobe and selects in that same cycle
  // REMOVE swaps the last entry in and reselects
  // SELECT holds the result for the done cycle
  typedef enum logic [1:0] {
    IDLE   = 2'd0,
    SELECT = 2'd1,
    REMOVE = 2'd2
  } state_t;

  state_t           state_q;
  logic [IDX_W-1:0] idx_q;
  logic [CNT_W-1:0] idx_ext;
  logic [CNT_W-1:0] last;
  logic [IDX_W-1:0] sel_idx;
  logic             start;
  logic             stop_match;
  logic             wrap;
  logic             take_rd;

  // strobes during a busy selection are dropped
  assign start   = (state_q == IDLE) && next_thread_i;
  assign idx_ext = CNT_W'(idx_q);
  assign last    = count_i - 1'b1;
  // round robin index sits on the last entry
  assign wrap    = (idx_ext >= last);
  // entry picked after a removal
  assign sel_idx = wrap ? '0 : idx_q;

  // entry under the index against the pending stop
  assign stop_match = stop_pend_i && (rd_ctx_i == stop_ctx_i) && (rd_addr_i == stop_addr_i);

  // table read value goes to the outputs
  assign take_rd = (start && !fork_pend_i && !stop_match) || (state_q == REMOVE);

  assign sched_done_o = (state_q == SELECT);

  // table and command unit strobes
  always_comb begin
    rd_idx_o    = idx_q;
    wr_en_o     = 1'b0;
    wr_idx_o    = idx_q;
    wr_ctx_o    = rd_ctx_i;
    wr_addr_o   = rd_addr_i;
    append_o    = 1'b0;
    remove_o    = 1'b0;
    fork_take_o = 1'b0;
    stop_hit_o  = 1'b0;
    sel_miss_o  = 1'b0;
    if (start && fork_pend_i) begin
      // parked fork goes in at the end of the table
      wr_en_o     = 1'b1;
      wr_idx_o    = count_i[IDX_W-1:0];
      wr_ctx_o    = fork_ctx_i;
      wr_addr_o   = fork_addr_i;
      append_o    = 1'b1;
      fork_take_o = 1'b1;
    end else if (start && (count_i != '0)) begin
      sel_miss_o = stop_pend_i && !stop_match;
    end else if (state_q == REMOVE) begin
      // read the last entry and copy it over the stopped one
      // no copy when the stopped one is the last
      rd_idx_o   = wrap ? '0 : last[IDX_W-1:0];
      wr_en_o    = !wrap;
      remove_o   = 1'b1;
      stop_hit_o = 1'b1;
    end
  end

  // fsm, round robin index and valid flag
  always_ff @(posedge clk) begin
    if (rst) begin
      state_q      <= IDLE;
      idx_q        <= '0;
      next_valid_o <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          if (start) begin
            state_q <= SELECT;
            if (fork_pend_i) begin
              next_valid_o <= 1'b1;
            end else if (count_i == '0) begin
              next_valid_o <= 1'b0;
            end else if (stop_match) begin
              state_q <= REMOVE;
            end else begin
              next_valid_o <= 1'b1;
              idx_q        <= wrap ? '0 : idx_q + 1'b1;
            end
          end
        end
        REMOVE: begin
          state_q <= SELECT;
          // last now holds the new count
          if (last == '0) begin
            next_valid_o <= 1'b0;
            idx_q        <= '0;
          end else begin
            next_valid_o <= 1'b1;
            idx_q        <= ((CNT_W'(sel_idx) + 1'b1) >= last) ? '0 : sel_idx + 1'b1;
          end
        end
        default: begin
          state_q <= IDLE;
        end
      endcase
    end
  end

  // selected thread
  always_ff @(posedge clk) begin
    if (start && fork_pend_i) begin
      next_ctx_o  <= fork_ctx_i;
      next_addr_o <= fork_addr_i;
    end else if (take_rd) begin
      next_ctx_o  <= rd_ctx_i;
      next_addr_o <= rd_addr_i;
    end
  end

  // done never stretches over two cycles
  a_done_pulse: assert property (
    @(posedge clk) disable iff (rst)
    sched_done_o |=> !sched_done_o
  );

  // a stop hit implies the table held the target
  a_no_remove_empty: assert property (
    @(posedge clk) disable iff (rst)
    remove_o |-> (count_i != '0)
  );

endmodule

`default_nettype wire

/* source/thread_cmd_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module thread_cmd_unit #(
  parameter int  PROC_QUANTITY = 8,
  localparam int CNT_W         = $clog2(PROC_QUANTITY + 1)
) (
  input  wire                           clk,
  input  wire                           rst,
  input  wire                           cmd_valid_i,
  input  wire thread_pkg::thread_cmd_t  cmd_i,
  input  wire [thread_pkg::CTX_W-1:0]   ctx_i,
  input  wire [thread_pkg::ADDR_W-1:0]  addr_i,
  input  wire [CNT_W-1:0]               count_i,
  input  wire                           fork_take_i,
  input  wire                           stop_hit_i,
  input  wire                           sel_miss_i,
  output logic                          fork_pend_o,
  output logic [thread_pkg::CTX_W-1:0]  fork_ctx_o,
  output logic [thread_pkg::ADDR_W-1:0] fork_addr_o,
  output logic                          stop_pend_o,
  output logic [thread_pkg::CTX_W-1:0]  stop_ctx_o,
  output logic [thread_pkg::ADDR_W-1:0] stop_addr_o,
  output thread_pkg::thread_rslt_t      rslt_o,
  output logic                          rslt_valid_o
);

  import thread_pkg::*;

  logic             run_req;
  logic             stop_req;
  logic             run_ok;
  logic             stop_ok;
  // selections left before a stop on an absent thread expires
  logic [CNT_W-1:0] miss_budget_q;

  assign run_req  = cmd_valid_i && (cmd_i == CMD_RUN);
  assign stop_req = cmd_valid_i && (cmd_i == CMD_STOP);

  // one fork slot, and the new thread must still fit the table
  assign run_ok  = !fork_pend_o && (count_i < CNT_W'(PROC_QUANTITY));
  // one stop slot
  assign stop_ok = !stop_pend_o;

  // pending fork flag
  // cleared once the scheduler appends it
  always_ff @(posedge clk) begin
    if (rst) begin
      fork_pend_o <= 1'b0;
    end else if (run_req && run_ok) begin
      fork_pend_o <= 1'b1;
    end else if (fork_take_i) begin
      fork_pend_o <= 1'b0;
    end
  end

  // slot payloads, loaded on accept only
  always_ff @(posedge clk) begin
    if (run_req && run_ok) begin
      fork_ctx_o  <= ctx_i;
      fork_addr_o <= addr_i;
    end
    if (stop_req && stop_ok) begin
      stop_ctx_o  <= ctx_i;
      stop_addr_o <= addr_i;
    end
  end

  // pending stop and its miss budget
  // budget starts at count so every entry is visited once
  always_ff @(posedge clk) begin
    if (rst) begin
      stop_pend_o   <= 1'b0;
      miss_budget_q <= '0;
    end else if (stop_req && stop_ok) begin
      // empty table, nothing to look for
      stop_pend_o   <= (count_i != '0);
      miss_budget_q <= count_i;
    end else if (stop_hit_i) begin
      stop_pend_o <= 1'b0;
    end else if (sel_miss_i && stop_pend_o) begin
      if (miss_budget_q <= CNT_W'(1)) begin
        // target never showed up
        stop_pend_o   <= 1'b0;
        miss_budget_q <= '0;
      end else begin
        miss_budget_q <= miss_budget_q - 1'b1;
      end
    end
  end

  // result one cycle after the command strobe
  always_ff @(posedge clk) begin
    if (rst) begin
      rslt_valid_o <= 1'b0;
      rslt_o       <= RSLT_NONE;
    end else begin
      rslt_valid_o <= cmd_valid_i;
      if (cmd_valid_i) begin
        case (cmd_i)
          CMD_RUN:  rslt_o <= run_ok ? RSLT_OK : RSLT_BUSY;
          CMD_STOP: rslt_o <= stop_ok ? RSLT_OK : RSLT_BUSY;
          default:  rslt_o <= RSLT_NONE;
        endcase
      end
    end
  end

  // scheduler takes the fork only while one is parked
  a_take_needs_fork: assert property (
    @(posedge clk) disable iff (rst)
    fork_take_i |-> fork_pend_o
  );

endmodule

`default_nettype wire

/* source/thread_table.sv */
`timescale 1ns/1ps
`default_nettype none

module thread_table #(
  parameter int  PROC_QUANTITY = 8,
  localparam int CNT_W         = $clog2(PROC_QUANTITY + 1),
  localparam int IDX_W         = (PROC_QUANTITY > 1) ? $clog2(PROC_QUANTITY) : 1
) (
  input  wire                           clk,
  input  wire                           rst,
  input  wire                           append_i,
  input  wire                           remove_i,
  input  wire                           wr_en_i,
  input  wire [IDX_W-1:0]               wr_idx_i,
  input  wire [thread_pkg::CTX_W-1:0]   wr_ctx_i,
  input  wire [thread_pkg::ADDR_W-1:0]  wr_addr_i,
  input  wire [IDX_W-1:0]               rd_idx_i,
  output logic [thread_pkg::CTX_W-1:0]  rd_ctx_o,
  output logic [thread_pkg::ADDR_W-1:0] rd_addr_o,
  output logic [CNT_W-1:0]              count_o
);

  import thread_pkg::*;

  // active thread entries
  // slots 0 .. count-1 are valid, the rest is stale
  logic [CTX_W-1:0]  ctx_mem  [PROC_QUANTITY];
  logic [ADDR_W-1:0] addr_mem [PROC_QUANTITY];

  // number of valid entries
  logic [CNT_W-1:0] count_q;

  // single write port
  // used for append at count and for the swap on removal
  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      ctx_mem[wr_idx_i]  <= wr_ctx_i;
      addr_mem[wr_idx_i] <= wr_addr_i;
    end
  end

  // thread count
  // append and remove never come together
  always_ff @(posedge clk) begin
    if (rst) begin
      count_q <= '0;
    end else if (append_i) begin
      count_q <= count_q + 1'b1;
    end else if (remove_i) begin
      count_q <= count_q - 1'b1;
    end
  end

  // combinational read for the scheduler compare
  assign rd_ctx_o  = ctx_mem[rd_idx_i];
  assign rd_addr_o = addr_mem[rd_idx_i];
  assign count_o   = count_q;

  // scheduler appends only what the command unit let in
  a_no_append_full: assert property (
    @(posedge clk) disable iff (rst)
    append_i |-> (count_q < CNT_W'(PROC_QUANTITY))
  );

  // removal needs a stop hit on a real entry
  a_no_remove_empty: assert property (
    @(posedge clk) disable iff (rst)
    remove_i |-> (count_q != '0)
  );

endmodule

`default_nettype wire

/* source/thread_pkg.sv */
`default_nettype none

package thread_pkg;

  // thread context word width
  parameter int CTX_W = 16;

  // thread entry address width
  parameter int ADDR_W = 12;

  // commands sent by the cpu
  typedef enum logic [1:0] {
    CMD_NONE = 2'd0,
    CMD_RUN  = 2'd1,
    CMD_STOP = 2'd2
  } thread_cmd_t;

  // command result
  // busy means the command was rejected
  typedef enum logic [1:0] {
    RSLT_BUSY = 2'd0,
    RSLT_OK   = 2'd1,
    RSLT_NONE = 2'd2
  } thread_rslt_t;

endpackage

`default_nettype wire
